/* filelist.f */
+incdir+common
common/idli_dcd_pkg.sv
common/idli_dcd_step_if.sv
decode/idli_dcd_seq.sv
decode/idli_dcd_opnd.sv
decode/idli_dcd_ctrl.sv
design/idli_decode.sv
tests/idli_tb_clkgen.sv
tests/idli_decode_chk.sv
tests/idli_decode_tb.sv

/* run.sh */
#!/bin/sh
# Builds the decoder testbench with Verilator and runs it.
# The run passes only if the simulation prints the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module idli_decode_tb -Mdir obj_dir -f filelist.f &&
./obj_dir/Vidli_decode_tb 2>&1 | tee /dev/stderr | grep -q "TEST PASS" &&
echo "Simulation passed" ||
{ echo "Simulation did not pass"; exit 1; }

/* tests/idli_decode_tb.sv */
`timescale 1ns/100ps

// Directed tests for the nibble-serial decoder.
module idli_decode_tb import idli_dcd_pkg::*;;

  // Clock, reset and DUT stimulus.
  logic        gck;
  logic        rst_n;
  sqi_data_t   enc;
  logic        enc_vld;
  logic        ex_redirect;

  // DUT outputs.
  op_t         op;
  logic        op_vld;

  // State of the pseudo random sequence.
  logic [31:0] lcg_state;

  idli_tb_clkgen idli_tb_clkgen_inst (.o_gck(gck));

  idli_decode idli_decode_inst (
    .i_dcd_gck         (gck),
    .i_dcd_rst_n       (rst_n),
    .i_dcd_enc         (enc),
    .i_dcd_enc_vld     (enc_vld),
    .i_dcd_ex_redirect (ex_redirect),
    .o_dcd_op          (op),
    .o_dcd_op_vld      (op_vld)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic match_op(input string name, input op_t exp, input op_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch in %s: expected op %h, actual op %h", name, exp, act));
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch in %s: expected valid %b, actual valid %b",
                              name, exp, act));
    end
  endtask

  // Plain 32b LCG. Low bits cycle quickly, so callers take upper bits.
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Expected operation, built from the instruction encoding rules.
  function automatic op_t expected_op(input sqi_data_t opc, input logic sel, input preg_t p,
                                      input greg_t a, input greg_t b, input greg_t c);
    op_t e;
    e.alu_op      = ALU_OP_ADD;
    e.alu_cin     = 1'b0;
    e.alu_rhs_inv = 1'b0;
    // SUB adds the inverted RHS plus one. ANDN only inverts the RHS.
    if (opc == 4'b1100) begin
      e.alu_cin     = sel;
      e.alu_rhs_inv = sel;
    end else if (opc == 4'b1101) begin
      e.alu_op      = ALU_OP_AND;
      e.alu_rhs_inv = sel;
    end else begin
      e.alu_op = sel ? ALU_OP_XOR : ALU_OP_OR;
    end
    e.rhs_src = (c == 3'b111) ? RHS_SRC_IMM : RHS_SRC_REG;
    e.p       = p;
    e.a       = a;
    e.b       = b;
    e.c       = c;
    return e;
  endfunction

  // Presents one nibble on the falling edge and samples the settled outputs
  // well before the next rising edge.
  task automatic drive_nibble(input sqi_data_t nib, input logic vld, input logic redirect,
                              output logic vld_seen, output op_t op_seen);
    @(negedge gck);
    enc         = nib;
    enc_vld     = vld;
    ex_redirect = redirect;
    #2;
    vld_seen = op_vld;
    op_seen  = op;
  endtask

  // Sends one ALU instruction. The valid is due on the fourth nibble and no sooner.
  task automatic send_alu(input string name, input sqi_data_t opc, input logic sel,
                          input preg_t p, input greg_t a, input greg_t b, input greg_t c,
                          input logic redirect);
    logic [15:0] word;
    logic        vld_seen;
    op_t         op_seen;
    word = {opc, sel, p, a, b, c};
    for (int i = 0; i < 4; i++) begin
      drive_nibble(word[15-4*i -: 4], 1'b1, (i == 3) ? redirect : 1'b0, vld_seen, op_seen);
      check_valid(name, i == 3, vld_seen);
    end
    match_op(name, expected_op(opc, sel, p, a, b, c), op_seen);
  endtask

  // Sends four valid nibbles that must not produce an operation.
  task automatic send_quiet(input string name, input logic [15:0] word);
    logic vld_seen;
    op_t  op_seen;
    for (int i = 0; i < 4; i++) begin
      drive_nibble(word[15-4*i -: 4], 1'b1, 1'b0, vld_seen, op_seen);
      check_valid(name, 1'b0, vld_seen);
    end
  endtask

  // Random fields, with C kept off the immediate marker.
  task automatic send_random_alu(input string name, input sqi_data_t opc, input logic sel);
    logic [31:0] r;
    r = next_rand();
    send_alu(name, opc, sel, preg_t'(r[9:8]), greg_t'(r[14:12]), greg_t'(r[18:16]),
             greg_t'(r[26:24] % 3'd7), 1'b0);
  endtask

  // Idle cycles with junk on the nibble bus.
  task automatic rest(input string name, input int cycles);
    logic [31:0] r;
    logic        vld_seen;
    op_t         op_seen;
    for (int i = 0; i < cycles; i++) begin
      r = next_rand();
      drive_nibble(r[23:20], 1'b0, 1'b0, vld_seen, op_seen);
      check_valid(name, 1'b0, vld_seen);
    end
  endtask

  task automatic test_register_ops();
    send_random_alu("add", 4'b1100, 1'b0);
    rest("add", 1);
    send_random_alu("sub", 4'b1100, 1'b1);
    rest("sub", 1);
    send_random_alu("and", 4'b1101, 1'b0);
    rest("and", 1);
    send_random_alu("andn", 4'b1101, 1'b1);
    rest("andn", 1);
    send_random_alu("or", 4'b1110, 1'b0);
    rest("or", 1);
    send_random_alu("xor", 4'b1110, 1'b1);
    rest("xor", 1);
  endtask

  task automatic test_back_to_back();
    logic [31:0] r;
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      send_random_alu("back_to_back", 4'b1100 + sqi_data_t'(r[28:27] % 2'd3), r[29]);
    end
    rest("back_to_back", 2);
  endtask

  // Last nibbles avoid C of all ones, which would start an immediate skip.
  task automatic test_nop();
    send_quiet("nop", 16'h0123);
    send_quiet("unsupported", 16'h5C84);
    send_quiet("unsupported", 16'hF000);
    send_random_alu("after_nop", 4'b1101, 1'b0);
    rest("after_nop", 1);
  endtask

  task automatic test_immediate();
    send_alu("imm", 4'b1110, 1'b1, 2'd1, 3'd5, 3'd2, 3'b111, 1'b0);
    send_quiet("imm_data", 16'hCD60);
    send_random_alu("after_imm", 4'b1100, 1'b1);
    rest("after_imm", 1);
  endtask

  task automatic test_redirect();
    send_alu("redirect", 4'b1100, 1'b1, 2'd2, 3'd3, 3'd6, 3'b111, 1'b1);
    send_random_alu("after_redirect", 4'b1110, 1'b0);
    rest("after_redirect", 1);
  endtask

  task automatic test_idle_reset();
    logic vld_seen;
    op_t  op_seen;
    rest("idle", 20);
    // Abandon an AND halfway through.
    drive_nibble(4'b1101, 1'b1, 1'b0, vld_seen, op_seen);
    check_valid("mid_reset", 1'b0, vld_seen);
    drive_nibble(4'b1010, 1'b1, 1'b0, vld_seen, op_seen);
    check_valid("mid_reset", 1'b0, vld_seen);
    // Reset lands on the third nibble's slot.
    @(negedge gck);
    rst_n = 1'b0;
    rest("mid_reset", 3);
    @(negedge gck);
    rst_n = 1'b1;
    send_random_alu("after_reset", 4'b1100, 1'b0);
    rest("after_reset", 1);
  endtask

  initial begin
    lcg_state   = 32'd65;
    rst_n       = 1'b0;
    enc         = '0;
    enc_vld     = 1'b0;
    ex_redirect = 1'b0;
    repeat (16) @(posedge gck);
    @(negedge gck);
    rst_n = 1'b1;
    test_register_ops();
    test_back_to_back();
    test_nop();
    test_immediate();
    test_redirect();
    test_idle_reset();
    $display("TEST PASS");
    $finish;
  end

  // Bounds the whole run in case a test stalls.
  initial begin
    for (int i = 0; i < 2000; i++) begin
      @(posedge gck);
    end
    $display("Timed out after 2000 clock cycles");
    $display("TEST FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* tests/idli_decode_chk.sv */
`timescale 1ns/100ps

// Assertions on the decoder outputs, bound into the top level.
module idli_decode_chk import idli_dcd_pkg::*; (
  input var logic i_dcd_gck,
  input var logic i_dcd_rst_n,
  input var op_t  i_dcd_op,
  input var logic i_dcd_op_vld
);

  // An instruction takes at least four nibbles, so valids can never be adjacent.
  a_vld_single: assert property (@(posedge i_dcd_gck) disable iff (!i_dcd_rst_n)
    i_dcd_op_vld |=> !i_dcd_op_vld)
    else $error("Operation valid was high on two consecutive cycles");

  // The sequencer sits in INIT while reset is held.
  a_vld_reset: assert property (@(posedge i_dcd_gck) !i_dcd_rst_n |-> !i_dcd_op_vld)
    else $error("Operation valid was high during reset");

  // An immediate RHS is encoded by a C field of all ones and nothing else.
  a_imm_c: assert property (@(posedge i_dcd_gck) disable iff (!i_dcd_rst_n)
    i_dcd_op_vld |-> ((i_dcd_op.rhs_src == RHS_SRC_IMM) == (i_dcd_op.c == 3'b111)))
    else $error("RHS source disagrees with the C field");

endmodule

bind idli_decode idli_decode_chk idli_decode_chk_inst (
  .i_dcd_gck    (i_dcd_gck),
  .i_dcd_rst_n  (i_dcd_rst_n),
  .i_dcd_op     (o_dcd_op),
  .i_dcd_op_vld (o_dcd_op_vld)
);

/* tests/idli_tb_clkgen.sv */
`timescale 1ns/100ps

// Free running clock for the testbench.
module idli_tb_clkgen (
  output var logic o_gck
);

  // Half of the 10 ns clock period.
  localparam int HALF_PERIOD = 5;

  // Start low so the first rising edge lands at 5 ns.
  initial begin
    o_gck = 1'b0;
    forever #HALF_PERIOD o_gck = ~o_gck;
  end

endmodule

/* design/idli_decode.sv */
`timescale 1ns/100ps

// Nibble-serial instruction decoder.
module idli_decode import idli_dcd_pkg::*; (
  // Clock and reset.
  input  var logic      i_dcd_gck,
  input  var logic      i_dcd_rst_n,

  // Instruction nibble and whether it is valid.
  input  var sqi_data_t i_dcd_enc,
  input  var logic      i_dcd_enc_vld,

  // Set when execute has redirected the instruction stream.
  input  var logic      i_dcd_ex_redirect,

  // Decoded operation and its valid.
  output var op_t       o_dcd_op,
  output var logic      o_dcd_op_vld
);

  // Field groups from the two decode units.
  preg_t    p;
  greg_t    a;
  greg_t    b;
  greg_t    c;
  alu_op_t  alu_op;
  logic     alu_cin;
  logic     alu_rhs_inv;
  rhs_src_t rhs_src;

  // Shared nibble stream and decode state.
  idli_dcd_step_if step ();

  assign step.enc     = i_dcd_enc;
  assign step.enc_vld = i_dcd_enc_vld;

  idli_dcd_seq idli_dcd_seq_inst (
    .i_dcd_gck         (i_dcd_gck),
    .i_dcd_rst_n       (i_dcd_rst_n),
    .i_dcd_ex_redirect (i_dcd_ex_redirect),
    .step              (step.seq)
  );

  idli_dcd_opnd idli_dcd_opnd_inst (
    .i_dcd_gck (i_dcd_gck),
    .step      (step.opnd),
    .o_dcd_p   (p),
    .o_dcd_a   (a),
    .o_dcd_b   (b),
    .o_dcd_c   (c)
  );

  idli_dcd_ctrl idli_dcd_ctrl_inst (
    .i_dcd_gck         (i_dcd_gck),
    .step              (step.ctrl),
    .o_dcd_alu_op      (alu_op),
    .o_dcd_alu_cin     (alu_cin),
    .o_dcd_alu_rhs_inv (alu_rhs_inv),
    .o_dcd_rhs_src     (rhs_src),
    .o_dcd_op_vld      (o_dcd_op_vld)
  );

  // Merge both field groups into the operation.
  assign o_dcd_op = '{alu_op: alu_op, alu_cin: alu_cin, alu_rhs_inv: alu_rhs_inv,
                      rhs_src: rhs_src, p: p, a: a, b: b, c: c};

endmodule

/* decode/idli_dcd_ctrl.sv */
`timescale 1ns/100ps

// Derives the ALU controls, RHS source and the output valid.
module idli_dcd_ctrl import idli_dcd_pkg::*; (
  // Clock for the control registers.
  input  var logic      i_dcd_gck,

  // Nibble stream, decode state and immediate flag.
  idli_dcd_step_if.ctrl step,

  // Decoded control fields.
  output var alu_op_t   o_dcd_alu_op,
  output var logic      o_dcd_alu_cin,
  output var logic      o_dcd_alu_rhs_inv,
  output var rhs_src_t  o_dcd_rhs_src,

  // Set for the single cycle in which the operation is valid.
  output var logic      o_dcd_op_vld
);

  // Nibble cycle of the current state.
  logic [1:0] cycle;

  // Held and next ALU controls.
  alu_op_t  alu_op_q;
  alu_op_t  alu_op_d;
  logic     alu_cin_q;
  logic     alu_cin_d;
  logic     alu_rhs_inv_q;
  logic     alu_rhs_inv_d;

  // RHS source, known only on the final nibble.
  rhs_src_t rhs_src;

  always_comb cycle = dcd_cycle(step.state);

  // Bit 3 of the second nibble picks the second member of each family.
  // SUB is ADD with the RHS inverted and a carry in.
  always_comb begin
    case (step.state)
      STATE_ADD_SUB: begin
        alu_op_d      = ALU_OP_ADD;
        alu_cin_d     = step.enc[3];
        alu_rhs_inv_d = step.enc[3];
      end
      STATE_AND_ANDN: begin
        alu_op_d      = ALU_OP_AND;
        alu_cin_d     = 1'b0;
        alu_rhs_inv_d = step.enc[3];
      end
      STATE_OR_XOR: begin
        alu_op_d      = step.enc[3] ? ALU_OP_XOR : ALU_OP_OR;
        alu_cin_d     = 1'b0;
        alu_rhs_inv_d = 1'b0;
      end
      STATE_ABC,
      STATE_BC: begin
        // Keep what was decoded until the instruction completes.
        alu_op_d      = alu_op_q;
        alu_cin_d     = alu_cin_q;
        alu_rhs_inv_d = alu_rhs_inv_q;
      end
      default: begin
        alu_op_d      = ALU_OP_ADD;
        alu_cin_d     = 1'b0;
        alu_rhs_inv_d = 1'b0;
      end
    endcase
  end

  // The held copy is only needed before the final nibble.
  always_ff @(posedge i_dcd_gck) begin
    if (step.enc_vld && cycle != 2'd3) begin
      alu_op_q      <= alu_op_d;
      alu_cin_q     <= alu_cin_d;
      alu_rhs_inv_q <= alu_rhs_inv_d;
    end
  end

  // A C field of all ones means the RHS comes from the following nibbles.
  always_comb begin
    if (cycle == 2'd3 && &step.enc[2:0]) begin
      rhs_src = RHS_SRC_IMM;
    end else begin
      rhs_src = RHS_SRC_REG;
    end
  end

  // Tell the sequencer to skip over the immediate.
  always_comb step.rhs_imm = rhs_src == RHS_SRC_IMM;

  always_comb begin
    o_dcd_alu_op      = alu_op_d;
    o_dcd_alu_cin     = alu_cin_d;
    o_dcd_alu_rhs_inv = alu_rhs_inv_d;
    o_dcd_rhs_src     = rhs_src;
  end

  // NOPs and immediate data end in other states, so only BC is valid.
  always_comb o_dcd_op_vld = step.state == STATE_BC;

endmodule

/* decode/idli_dcd_opnd.sv */
`timescale 1ns/100ps

// Collects the P, A, B and C fields as the nibbles arrive.
module idli_dcd_opnd import idli_dcd_pkg::*; (
  // Clock for the field registers.
  input  var logic     i_dcd_gck,

  // Nibble stream and decode state.
  idli_dcd_step_if.opnd step,

  // Decoded operand fields.
  output var preg_t    o_dcd_p,
  output var greg_t    o_dcd_a,
  output var greg_t    o_dcd_b,
  output var greg_t    o_dcd_c
);

  // Nibble cycle of the current state.
  logic [1:0] cycle;

  // Flopped fields hold partial values between nibbles.
  preg_t p_q;
  greg_t a_q;
  greg_t b_q;

  // Next values, which are also the outputs on the final cycle.
  preg_t p_d;
  greg_t a_d;
  greg_t b_d;
  greg_t c_d;

  always_comb cycle = dcd_cycle(step.state);

  // Fields sit at the same bit positions for every instruction, so they
  // are picked out on the cycle alone.
  always_comb begin
    p_d = p_q;
    a_d = a_q;
    b_d = b_q;
    c_d = '0;

    case (cycle)
      2'd1: begin
        a_d[2] = step.enc[0];

        // NOPs are never predicated so they always use the true predicate.
        if (step.state == STATE_NOP_FAM) begin
          p_d = PREG_PT;
        end else begin
          p_d = preg_t'(step.enc[2:1]);
        end
      end
      2'd2: begin
        a_d[1:0] = step.enc[3:2];
        b_d[2:1] = step.enc[1:0];
      end
      2'd3: begin
        // C arrives whole in the final nibble, so it is never flopped.
        b_d[0] = step.enc[3];
        c_d    = greg_t'(step.enc[2:0]);
      end
      default: begin
      end
    endcase
  end

  // Only the first three nibbles need storing; the last goes straight out.
  always_ff @(posedge i_dcd_gck) begin
    if (step.enc_vld && cycle != 2'd3) begin
      p_q <= p_d;
      a_q <= a_d;
      b_q <= b_d;
    end
  end

  // Outputs are the unflopped values so execute can register them at once.
  always_comb begin
    o_dcd_p = p_d;
    o_dcd_a = a_d;
    o_dcd_b = b_d;
    o_dcd_c = c_d;
  end

endmodule

/* decode/idli_dcd_seq.sv */
`timescale 1ns/100ps

// Tracks progress through the four nibbles of an instruction.
module idli_dcd_seq import idli_dcd_pkg::*; (
  // Clock and reset.
  input  var logic    i_dcd_gck,
  input  var logic    i_dcd_rst_n,

  // Set when execute has redirected the instruction stream.
  input  var logic    i_dcd_ex_redirect,

  // Nibble stream and decode state.
  idli_dcd_step_if.seq step
);

  // Current and next decode state.
  state_t state_q;
  state_t state_d;

  // Flop the state, returning to INIT on reset.
  always_ff @(posedge i_dcd_gck, negedge i_dcd_rst_n) begin
    if (!i_dcd_rst_n) begin
      state_q <= STATE_INIT;
    end else begin
      state_q <= state_d;
    end
  end

  // Work out the next state from the current one and the opcode.
  always_comb begin
    state_d = state_q;

    case (state_q)
      STATE_INIT: begin
        // A valid nibble while idle starts a new instruction. Anything that
        // isn't one of the supported ALU families is treated as a NOP.
        if (step.enc_vld) begin
          case (step.enc)
            4'b1100: state_d = STATE_ADD_SUB;
            4'b1101: state_d = STATE_AND_ANDN;
            4'b1110: state_d = STATE_OR_XOR;
            default: state_d = STATE_NOP_FAM;
          endcase
        end
      end
      STATE_ADD_SUB,
      STATE_AND_ANDN,
      STATE_OR_XOR: begin
        // Operation is known, so only operands remain.
        state_d = STATE_ABC;
      end
      STATE_ABC: begin
        // Last nibble holds the rest of B and all of C.
        state_d = STATE_BC;
      end
      STATE_NOP_FAM: begin
        // NOPs consume the full instruction width.
        state_d = STATE_NOP_0;
      end
      STATE_NOP_0: begin
        state_d = STATE_NOP_1;
      end
      STATE_IMM_0: begin
        // Immediate data is skipped a nibble at a time.
        state_d = STATE_IMM_1;
      end
      STATE_IMM_1: begin
        state_d = STATE_IMM_2;
      end
      STATE_IMM_2: begin
        state_d = STATE_IMM_3;
      end
      default: begin
        // Final cycle states go back to idle, unless an immediate follows.
        // A redirect throws the immediate away so we start afresh instead.
        if (dcd_cycle(state_q) == 2'd3) begin
          if (step.rhs_imm && !i_dcd_ex_redirect) begin
            state_d = STATE_IMM_0;
          end else begin
            state_d = STATE_INIT;
          end
        end else begin
          // Unused encodings recover to idle.
          state_d = STATE_INIT;
        end
      end
    endcase
  end

  // Share the state with the decode units.
  always_comb step.state = state_q;

endmodule

/* common/idli_dcd_step_if.sv */
`timescale 1ns/100ps

// Carries the current nibble and decode progress to the decode units.
interface idli_dcd_step_if import idli_dcd_pkg::*;;

  // Current nibble of the encoding and whether it is valid.
  sqi_data_t enc;
  logic      enc_vld;

  // Decode state, owned by the sequencer.
  state_t    state;

  // Set on the final nibble when the instruction takes an immediate.
  logic      rhs_imm;

  // The sequencer needs the immediate flag to pick its next state.
  modport seq (
    input  enc, enc_vld, rhs_imm,
    output state
  );

  // Operand extraction only watches the nibble stream.
  modport opnd (
    input  enc, enc_vld, state
  );

  // Control decode reports back whether an immediate follows.
  modport ctrl (
    input  enc, enc_vld, state,
    output rhs_imm
  );

endinterface

/* common/idli_dcd_pkg.sv */
`include "idli_dcd_defines.svh"

package idli_dcd_pkg;

  // One nibble of the instruction encoding, plus register indices.
  typedef logic [`IDLI_NIBBLE_W-1:0] sqi_data_t;
  typedef logic [`IDLI_GREG_W-1:0]   greg_t;
  typedef logic [`IDLI_PREG_W-1:0]   preg_t;

  // The predicate that always evaluates as true.
  localparam preg_t PREG_PT = preg_t'(2'b11);

  // Decode progress. The top 2b of each encoding hold the nibble cycle.
  typedef enum logic [5:0] {
    STATE_INIT     = 6'b000000,
    STATE_IMM_0    = 6'b001111,
    STATE_NOP_FAM  = 6'b010000,
    STATE_ADD_SUB  = 6'b011000,
    STATE_AND_ANDN = 6'b011001,
    STATE_OR_XOR   = 6'b011010,
    STATE_IMM_1    = 6'b011111,
    STATE_NOP_0    = 6'b100000,
    STATE_ABC      = 6'b100100,
    STATE_IMM_2    = 6'b101111,
    STATE_NOP_1    = 6'b110000,
    STATE_BC       = 6'b110001,
    STATE_IMM_3    = 6'b111111
  } state_t;

  // Returns which nibble of the instruction the given state consumes.
  function automatic logic [1:0] dcd_cycle(state_t state);
    return state[5:4];
  endfunction

  // ALU operation and RHS source selections.
  typedef enum logic [1:0] {ALU_OP_ADD, ALU_OP_AND, ALU_OP_OR, ALU_OP_XOR} alu_op_t;
  typedef enum logic {RHS_SRC_REG, RHS_SRC_IMM} rhs_src_t;

  // The decoded operation as handed to execute.
  typedef struct packed {
    alu_op_t  alu_op;
    logic     alu_cin;
    logic     alu_rhs_inv;
    rhs_src_t rhs_src;
    preg_t    p;
    greg_t    a;
    greg_t    b;
    greg_t    c;
  } op_t;

endpackage

/* common/idli_dcd_defines.svh */
`ifndef IDLI_DCD_DEFINES_SVH
`define IDLI_DCD_DEFINES_SVH

// Width of one instruction nibble.
// The encoding is delivered 4b per cycle over the serial interface.
`define IDLI_NIBBLE_W 4

// Width of a general register index.
// Eight general registers are addressable by the A, B and C operands.
`define IDLI_GREG_W 3

// Width of a predicate register index.
// Four predicates exist, one of which always reads as true.
`define IDLI_PREG_W 2

`endif
